// ==== axis_pkg.sv ====
`default_nettype none

package axis_pkg;

  // ====================================================================
  // widths
  // ====================================================================

  localparam int byte_width = 8;                        // bits per lane
  localparam int wide_bytes = 8;                        // lanes on the wide side
  localparam int wide_width = wide_bytes * byte_width;

  // ====================================================================
  // beat fields
  // ====================================================================

  typedef logic [wide_width-1:0] wide_data_t;           // one wide beat
  typedef logic [wide_bytes-1:0] wide_keep_t;           // lane enables
  typedef logic [byte_width-1:0] byte_t;                // one byte beat

  // lane counter shared by both converters
  typedef logic [$clog2(wide_bytes)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// ==== axis_if.sv ====
`default_nettype none

interface axis_if import axis_pkg::*; #(
  parameter int bytes = 1
);

  logic [bytes*byte_width-1:0] data;
  logic [bytes-1:0]            keep;
  logic                        valid;
  logic                        ready;
  logic                        last;   // end of frame
  logic                        user;   // frame-level flag, rides with last

  // payload holds while valid is up and ready is down
  modport src (
    output data, keep, valid, last, user,
    input  ready
  );

  modport snk (
    input  data, keep, valid, last, user,
    output ready
  );

endinterface

`default_nettype wire

// ==== axis_skid_reg.sv ====
`default_nettype none

module axis_skid_reg import axis_pkg::*; #(
  parameter int bytes = 1
) (
  input  logic clk,
  input  logic rst,
  axis_if.snk  s,
  axis_if.src  m
);

  // payload packed as {data, keep, last, user}
  logic [bytes*byte_width+bytes+1:0] in_beat;
  logic [bytes*byte_width+bytes+1:0] out_beat;
  logic [bytes*byte_width+bytes+1:0] tmp_beat;
  logic out_valid;
  logic tmp_valid;
  logic in_ready;      // registered ready towards the source
  logic ready_early;
  logic load_out;
  logic load_tmp;
  logic tmp_to_out;

  assign in_beat = {s.data, s.keep, s.last, s.user};
  assign {m.data, m.keep, m.last, m.user} = out_beat;
  assign m.valid = out_valid;
  assign s.ready = in_ready;

  // ready next cycle if the output drains now, or the temp slot is
  // empty and nothing is about to land in it
  assign ready_early = m.ready | (~tmp_valid & (~out_valid | ~s.valid));

  assign load_out   = in_ready & (m.ready | ~out_valid);
  assign load_tmp   = in_ready & ~m.ready & out_valid;   // output stalled
  assign tmp_to_out = ~in_ready & m.ready;

  // ====================================================================
  // control
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
      tmp_valid <= 1'b0;
    end else begin
      in_ready <= ready_early;
      if (load_out) begin
        out_valid <= s.valid;
      end else if (tmp_to_out) begin
        out_valid <= tmp_valid;
        tmp_valid <= 1'b0;
      end
      if (load_tmp) tmp_valid <= s.valid;
    end
  end

  // ====================================================================
  // payload
  // ====================================================================

  always_ff @(posedge clk) begin
    if (load_out) begin
      out_beat <= in_beat;
    end else if (tmp_to_out) begin
      out_beat <= tmp_beat;
    end
    if (load_tmp) tmp_beat <= in_beat;
  end

endmodule

`default_nettype wire

// ==== axis_downsizer.sv ====
`default_nettype none

module axis_downsizer import axis_pkg::*; (
  input  logic clk,
  input  logic rst,
  axis_if.snk  wide_in,
  axis_if.src  byte_out
);

  typedef enum logic {
    idle,
    split
  } state_t;

  state_t     state;
  lane_idx_t  lane;        // lane being presented in split
  lane_idx_t  next_lane;
  wide_data_t hold_data;
  wide_keep_t hold_keep;
  logic       hold_last;
  logic       hold_user;
  logic       final_byte;  // no more kept lanes after this one
  logic       byte_take;
  logic       wide_take;

  assign next_lane = lane + 3'd1;

  // ====================================================================
  // byte output and wide ready
  // ====================================================================

  always_comb begin
    if (state == idle) begin
      // lane 0 goes straight out, same cycle as the wide beat
      byte_out.valid = wide_in.valid;
      byte_out.data  = wide_in.data[byte_width-1:0];
      final_byte     = ~wide_in.keep[1];
      byte_out.last  = wide_in.last & final_byte;
      byte_out.user  = wide_in.user & final_byte;
      wide_in.ready  = byte_out.ready;
    end else begin
      byte_out.valid = 1'b1;
      byte_out.data  = hold_data[lane*byte_width +: byte_width];
      final_byte     = (lane == 3'd7) | ~hold_keep[next_lane];
      byte_out.last  = hold_last & final_byte;
      byte_out.user  = hold_user & final_byte;
      wide_in.ready  = byte_out.ready & final_byte;  // refill behind the final byte
    end
  end

  assign byte_out.keep = 1'b1;

  assign byte_take = byte_out.valid & byte_out.ready;
  assign wide_take = wide_in.valid & wide_in.ready;

  // ====================================================================
  // state
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      lane  <= '0;
    end else if (wide_take) begin
      if (state == idle) begin
        state <= final_byte ? idle : split;
        lane  <= 3'd1;               // lane 0 already sent
      end else begin
        state <= split;              // new beat, nothing of it sent yet
        lane  <= '0;
      end
    end else if (byte_take) begin
      if (final_byte) state <= idle;
      lane <= next_lane;
    end
  end

  always_ff @(posedge clk) begin
    if (wide_take) begin
      hold_data <= wide_in.data;
      hold_keep <= wide_in.keep;
      hold_last <= wide_in.last;
      hold_user <= wide_in.user;
    end
  end

endmodule

`default_nettype wire

// ==== axis_upsizer.sv ====
`default_nettype none

module axis_upsizer import axis_pkg::*; (
  input  logic clk,
  input  logic rst,
  axis_if.snk  byte_in,
  axis_if.src  wide_out
);

  typedef enum logic {
    fill,
    emit
  } state_t;

  state_t     state;
  lane_idx_t  ptr;         // next lane to fill
  lane_idx_t  wr_lane;
  wide_data_t acc_data;
  wide_keep_t acc_keep;
  wide_keep_t keep_base;
  wide_keep_t lane_bit;
  wide_data_t out_data;
  logic       acc_last;
  logic       acc_user;
  logic       byte_take;
  logic       wide_take;
  logic       closing;     // this byte completes a wide beat

  assign wide_take = wide_out.valid & wide_out.ready;

  // follows the output stage, so a byte taken in emit always
  // coincides with the packed beat leaving
  assign byte_in.ready = wide_out.ready;
  assign byte_take     = byte_in.valid & byte_in.ready;

  // ====================================================================
  // accumulation
  // ====================================================================

  assign wr_lane   = (state == emit) ? '0 : ptr;       // emit restarts at lane 0
  assign keep_base = (state == emit) ? '0 : acc_keep;
  assign lane_bit  = wide_keep_t'(byte_in.keep) << wr_lane;
  assign closing   = (wr_lane == 3'd7) | byte_in.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= fill;
      ptr      <= '0;
      acc_keep <= '0;
    end else if (byte_take) begin
      acc_keep <= keep_base | lane_bit;
      ptr      <= wr_lane + 3'd1;
      state    <= closing ? emit : fill;
    end else if (wide_take) begin
      acc_keep <= '0;
      ptr      <= '0;
      state    <= fill;
    end
  end

  always_ff @(posedge clk) begin
    if (byte_take) begin
      acc_data[wr_lane*byte_width +: byte_width] <= byte_in.data;
      acc_last <= byte_in.last;  // closing byte is the one that sticks
      acc_user <= byte_in.user;
    end
  end

  // ====================================================================
  // wide output
  // ====================================================================

  // unfilled lanes read as zero
  always_comb begin
    for (int i = 0; i < wide_bytes; i++) begin
      out_data[i*byte_width +: byte_width] =
        acc_keep[i] ? acc_data[i*byte_width +: byte_width] : '0;
    end
  end

  assign wide_out.valid = (state == emit);
  assign wide_out.data  = out_data;
  assign wide_out.keep  = acc_keep;
  assign wide_out.last  = acc_last;
  assign wide_out.user  = acc_user;

endmodule

`default_nettype wire

// ==== axis_width_bridge.sv ====
`default_nettype none

module axis_width_bridge import axis_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // wide in, downsizer path
  input  wide_data_t wide_in_data,
  input  wide_keep_t wide_in_keep,
  input  logic       wide_in_valid,
  output logic       wide_in_ready,
  input  logic       wide_in_last,
  input  logic       wide_in_user,
  // byte out
  output byte_t      byte_out_data,
  output logic       byte_out_keep,
  output logic       byte_out_valid,
  input  logic       byte_out_ready,
  output logic       byte_out_last,
  output logic       byte_out_user,
  // byte in, upsizer path
  input  byte_t      byte_in_data,
  input  logic       byte_in_keep,
  input  logic       byte_in_valid,
  output logic       byte_in_ready,
  input  logic       byte_in_last,
  input  logic       byte_in_user,
  // wide out
  output wide_data_t wide_out_data,
  output wide_keep_t wide_out_keep,
  output logic       wide_out_valid,
  input  logic       wide_out_ready,
  output logic       wide_out_last,
  output logic       wide_out_user
);

  axis_if #(.bytes(wide_bytes)) wide_in_if ();
  axis_if #(.bytes(1))          down_if ();
  axis_if #(.bytes(1))          byte_out_if ();
  axis_if #(.bytes(1))          byte_in_if ();
  axis_if #(.bytes(wide_bytes)) up_if ();
  axis_if #(.bytes(wide_bytes)) wide_out_if ();

  // ====================================================================
  // wide to byte
  // ====================================================================

  assign wide_in_if.data  = wide_in_data;
  assign wide_in_if.keep  = wide_in_keep;
  assign wide_in_if.valid = wide_in_valid;
  assign wide_in_if.last  = wide_in_last;
  assign wide_in_if.user  = wide_in_user;
  assign wide_in_ready    = wide_in_if.ready;

  axis_downsizer down0 (.clk(clk), .rst(rst), .wide_in(wide_in_if.snk), .byte_out(down_if.src));

  axis_skid_reg #(.bytes(1)) byte_skid0 (.clk(clk), .rst(rst), .s(down_if.snk), .m(byte_out_if.src));

  assign byte_out_data     = byte_out_if.data;
  assign byte_out_keep     = byte_out_if.keep;
  assign byte_out_valid    = byte_out_if.valid;
  assign byte_out_if.ready = byte_out_ready;
  assign byte_out_last     = byte_out_if.last;
  assign byte_out_user     = byte_out_if.user;

  // ====================================================================
  // byte to wide
  // ====================================================================

  assign byte_in_if.data  = byte_in_data;
  assign byte_in_if.keep  = byte_in_keep;
  assign byte_in_if.valid = byte_in_valid;
  assign byte_in_if.last  = byte_in_last;
  assign byte_in_if.user  = byte_in_user;
  assign byte_in_ready    = byte_in_if.ready;

  axis_upsizer up0 (.clk(clk), .rst(rst), .byte_in(byte_in_if.snk), .wide_out(up_if.src));

  axis_skid_reg #(.bytes(wide_bytes)) wide_skid0 (
    .clk(clk),
    .rst(rst),
    .s(up_if.snk),
    .m(wide_out_if.src)
  );

  assign wide_out_data     = wide_out_if.data;
  assign wide_out_keep     = wide_out_if.keep;
  assign wide_out_valid    = wide_out_if.valid;
  assign wide_out_if.ready = wide_out_ready;
  assign wide_out_last     = wide_out_if.last;
  assign wide_out_user     = wide_out_if.user;

endmodule

`default_nettype wire

// ==== tb_axis_width_bridge.sv ====
`default_nettype none

module tb_axis_width_bridge import axis_pkg::*; ();

  localparam int period      = 100;
  localparam int down_frames = 40;
  localparam int up_frames   = 40;
  localparam int both_frames = 12;

  logic       clk;
  logic       rst;
  wide_data_t wide_in_data;
  wide_keep_t wide_in_keep;
  logic       wide_in_valid, wide_in_ready, wide_in_last, wide_in_user;
  byte_t      byte_out_data;
  logic       byte_out_keep, byte_out_valid, byte_out_last, byte_out_user;
  logic       byte_out_ready = 1'b0;
  byte_t      byte_in_data;
  logic       byte_in_keep, byte_in_valid, byte_in_ready, byte_in_last, byte_in_user;
  wide_data_t wide_out_data;
  wide_keep_t wide_out_keep;
  logic       wide_out_valid, wide_out_last, wide_out_user;
  logic       wide_out_ready = 1'b0;

  // beats as {data, keep, last, user}, byte side zero-extended
  logic [73:0] exp_bytes[$];
  logic [73:0] exp_wides[$];
  logic [73:0] byte_now;
  logic [73:0] wide_now;
  logic [73:0] byte_prev;
  logic [73:0] wide_prev;
  logic        byte_stall;
  logic        wide_stall;
  int errors;
  int user_errors;
  int hold_errors;
  int tests_run;
  int tests_failed;
  int cycles;
  int cycle_limit = 200;   // grows by two per generated byte

  axis_width_bridge dut0 (.*);

  assign byte_now = {56'b0, byte_out_data, 7'b0, byte_out_keep, byte_out_last, byte_out_user};
  assign wide_now = {wide_out_data, wide_out_keep, wide_out_last, wide_out_user};

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with beats still outstanding", cycles);
    $display("tests failed");
    $finish;
  end

  // output back-pressure, about 70 percent ready
  always @(negedge clk) begin
    byte_out_ready = ($urandom_range(99) < 70);
    wide_out_ready = ($urandom_range(99) < 70);
  end

  // ====================================================================
  // reporting
  // ====================================================================

  function automatic void show_mismatch(string name, logic [63:0] e, logic [63:0] g);
    $display("Mismatch at %0t: %s expected %h got %h", $time, name, e, g);
    errors++;
  endfunction

  function automatic void note_failure(string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endfunction

  function automatic bit compare_beat(string side, logic [73:0] e, logic [73:0] g);
    if (g[73:10] != e[73:10]) show_mismatch({side, "_data"}, e[73:10], g[73:10]);
    if (g[9:2] != e[9:2]) show_mismatch({side, "_keep"}, 64'(e[9:2]), 64'(g[9:2]));
    if (g[1] != e[1]) show_mismatch({side, "_last"}, 64'(e[1]), 64'(g[1]));
    if (g[0] != e[0]) show_mismatch({side, "_user"}, 64'(e[0]), 64'(g[0]));
    return g != e;
  endfunction

  function automatic void close_test(string name, int failures);
    tests_run++;
    if (failures == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, failures);
    end
  endfunction

  // ====================================================================
  // stimulus and model
  // ====================================================================

  task automatic send_wide_frames(int frames);
    int   beats;
    int   lanes;
    logic user;
    logic taken;
    for (int f = 0; f < frames; f++) begin
      beats = $urandom_range(6, 1);
      user  = ($urandom_range(1) == 1);
      for (int b = 0; b < beats; b++) begin
        lanes = (b == beats - 1) ? $urandom_range(8, 1) : wide_bytes;
        cycle_limit += 2 * lanes;
        @(negedge clk);
        if ($urandom_range(7) == 0) begin   // idle gap now and then
          wide_in_valid = 1'b0;
          @(negedge clk);
        end
        wide_in_data  = {$urandom, $urandom};
        wide_in_keep  = 8'((1 << lanes) - 1);   // contiguous from lane 0
        wide_in_last  = (b == beats - 1);
        wide_in_user  = user & wide_in_last;
        wide_in_valid = 1'b1;
        // ready is looked at before the edge that would take the beat
        do begin
          #(period / 4);
          taken = wide_in_ready;
          @(posedge clk);
        end while (!taken);
        // kept lanes in order, last and user only on the final one
        for (int i = 0; i < lanes; i++) begin
          exp_bytes.push_back({56'b0, wide_in_data[8*i +: 8], 8'h01,
                               wide_in_last && i == lanes - 1,
                               wide_in_user && i == lanes - 1});
        end
      end
    end
    @(negedge clk);
    wide_in_valid = 1'b0;
  endtask

  task automatic stream_byte_frames(int frames);
    int         len;
    int         fill;
    logic       user;
    logic       taken;
    wide_data_t acc;
    fill = 0;
    acc  = '0;
    for (int f = 0; f < frames; f++) begin
      len  = $urandom_range(30, 1);
      user = ($urandom_range(1) == 1);
      cycle_limit += 2 * len;
      for (int i = 0; i < len; i++) begin
        @(negedge clk);
        if ($urandom_range(7) == 0) begin
          byte_in_valid = 1'b0;
          @(negedge clk);
        end
        byte_in_data  = 8'($urandom);
        byte_in_last  = (i == len - 1);
        byte_in_user  = user & byte_in_last;
        byte_in_valid = 1'b1;
        do begin
          #(period / 4);
          taken = byte_in_ready;
          @(posedge clk);
        end while (!taken);
        acc[fill*8 +: 8] = byte_in_data;
        fill++;
        if (fill == wide_bytes || byte_in_last) begin   // closing byte
          exp_wides.push_back({acc, 8'((1 << fill) - 1), byte_in_last, byte_in_user});
          acc  = '0;
          fill = 0;
        end
      end
    end
    @(negedge clk);
    byte_in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_bytes.size() != 0 || exp_wides.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);   // room for a stray extra beat to show up
  endtask

  // ====================================================================
  // output monitors
  // ====================================================================

  always @(posedge clk) begin
    if (rst) begin
      byte_stall = 1'b0;
    end else begin
      if (byte_stall && !byte_out_valid) begin
        note_failure("byte_out_valid dropped under back-pressure");
        hold_errors++;
      end else if (byte_stall) begin
        hold_errors += int'(compare_beat("byte_out", byte_prev, byte_now));
      end
      if (byte_out_valid && byte_out_ready) begin
        if (exp_bytes.size() == 0) note_failure("byte beat arrived with none expected");
        else void'(compare_beat("byte_out", exp_bytes.pop_front(), byte_now));
      end
      if (byte_out_valid && byte_out_user && !byte_out_last) begin
        note_failure("byte_out_user set without byte_out_last");
        user_errors++;
      end
      byte_stall = byte_out_valid && !byte_out_ready;
      byte_prev  = byte_now;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      wide_stall = 1'b0;
    end else begin
      if (wide_stall && !wide_out_valid) begin
        note_failure("wide_out_valid dropped under back-pressure");
        hold_errors++;
      end else if (wide_stall) begin
        hold_errors += int'(compare_beat("wide_out", wide_prev, wide_now));
      end
      if (wide_out_valid && wide_out_ready) begin
        if (exp_wides.size() == 0) note_failure("wide beat arrived with none expected");
        else void'(compare_beat("wide_out", exp_wides.pop_front(), wide_now));
      end
      if (wide_out_valid && wide_out_user && !wide_out_last) begin
        note_failure("wide_out_user set without wide_out_last");
        user_errors++;
      end
      wide_stall = wide_out_valid && !wide_out_ready;
      wide_prev  = wide_now;
    end
  end

  // ====================================================================
  // test sequence
  // ====================================================================

  initial begin
    int mark;
    int user_mark;
    int hold_mark;
    void'($urandom(11));
    rst           = 1'b1;
    wide_in_data  = '0;
    wide_in_keep  = '0;
    wide_in_valid = 1'b0;
    wide_in_last  = 1'b0;
    wide_in_user  = 1'b0;
    byte_in_data  = '0;
    byte_in_keep  = 1'b1;   // byte beats always carry keep 1
    byte_in_valid = 1'b0;
    byte_in_last  = 1'b0;
    byte_in_user  = 1'b0;

    mark = errors;
    repeat (5) begin
      @(posedge clk);
      if (byte_out_valid) show_mismatch("byte_out_valid", 64'(0), 64'(byte_out_valid));
      if (wide_out_valid) show_mismatch("wide_out_valid", 64'(0), 64'(wide_out_valid));
    end
    @(negedge clk);
    rst = 1'b0;
    repeat (2) begin
      @(posedge clk);
      if (byte_out_valid) show_mismatch("byte_out_valid", 64'(0), 64'(byte_out_valid));
      if (wide_out_valid) show_mismatch("wide_out_valid", 64'(0), 64'(wide_out_valid));
    end
    if (!wide_in_ready) show_mismatch("wide_in_ready", 64'(1), 64'(wide_in_ready));
    if (!byte_in_ready) show_mismatch("byte_in_ready", 64'(1), 64'(byte_in_ready));
    close_test("reset", errors - mark);

    mark      = errors;
    user_mark = user_errors;
    hold_mark = hold_errors;
    send_wide_frames(down_frames);
    wait_drain();
    close_test("downsize", errors - mark);

    mark = errors;
    stream_byte_frames(up_frames);
    wait_drain();
    close_test("upsize", errors - mark);
    close_test("user flag", user_errors - user_mark);
    close_test("back-pressure", hold_errors - hold_mark);

    mark = errors;
    fork
      send_wide_frames(both_frames);
      stream_byte_frames(both_frames);
    join
    wait_drain();
    close_test("concurrent", errors - mark);

    $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
axis_pkg.sv
axis_if.sv
axis_skid_reg.sv
axis_downsizer.sv
axis_upsizer.sv
axis_width_bridge.sv
tb_axis_width_bridge.sv

// ==== run.sh ====
#!/bin/sh
# build and run the width bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_axis_width_bridge
log=sim.log

verilator --binary --timing --top-module "$top" -f flist.f -o "$top"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
